/* verilog.f */
+incdir+include
rtl/ccu_pkg.sv
rtl/ccu_ctrl_fsm.sv
rtl/ccu_req_slot.sv
rtl/isa_fetch.sv
rtl/isa_decoder.sv
rtl/ccu_top.sv
verif/isa_ram_model.sv
verif/tb_ccu_top.sv

/* verif/tb_ccu_top.sv */
/*
 * Testbench for the configuration control unit. Loads a three-layer
 * program into the RAM model, plays the KNN and SYA modules with
 * random ready, and checks the DUT with concurrent assertions.
 */
`timescale 1ns/1ns
`include "ccu_defs.svh"

module tb_ccu_top;
    import ccu_pkg::*;

    localparam int N_LY    = 3;         // Layers in the program
    localparam int TIMEOUT = 5000;      // Cycles

    logic                       clk         = 1'b0;
    logic                       rst_n       = 1'b0;
    logic                       start       = 1'b0;
    logic                       knn_cfg_rdy = 1'b0;
    logic                       sya_cfg_rdy = 1'b0;
    logic                       net_fnh;
    logic [`CCU_ADDR_WIDTH-1:0] isa_rd_addr;
    logic                       isa_rd_addr_vld;
    logic                       isa_rd_addr_rdy;
    logic [`CCU_SRAM_WIDTH-1:0] isa_rd_dat;
    logic                       isa_rd_dat_vld;
    logic                       isa_rd_dat_rdy;
    logic [`CCU_ADDR_WIDTH-1:0] isa_rd_addr_min;
    logic                       mdu_rst;
    logic                       knn_cfg_vld;
    logic                       sya_cfg_vld;
    knn_cfg_t                   knn_cfg;
    sya_cfg_t                   sya_cfg;

    knn_cfg_t                   exp_knn [N_LY];
    sya_cfg_t                   exp_sya [N_LY];
    int                         knn_cnt     = 0;    // Config handshakes so far
    int                         sya_cnt     = 0;
    int                         fnh_cnt     = 0;
    int                         assert_errs = 0;
    int                         other_errs  = 0;
    int                         cyc;
    logic                       started     = 1'b0;
    logic                       first_pend  = 1'b1; // No address since start
    logic                       have_prev   = 1'b0;
    logic                       ccu_seen    = 1'b0; // Control word returned
    logic [`CCU_ADDR_WIDTH-1:0] prev_addr   = '0;
    logic [`CCU_ADDR_WIDTH-1:0] min_peak    = '0;   // Highest minimum since start
    logic                       addr_hs;
    logic                       dat_hs;

    always #50 clk = ~clk;

    assign addr_hs = isa_rd_addr_vld && isa_rd_addr_rdy;
    assign dat_hs  = isa_rd_dat_vld && isa_rd_dat_rdy;

    ccu_top dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_i           (start),
        .net_fnh_o         (net_fnh),
        .isa_rd_addr_o     (isa_rd_addr),
        .isa_rd_addr_vld_o (isa_rd_addr_vld),
        .isa_rd_addr_rdy_i (isa_rd_addr_rdy),
        .isa_rd_dat_i      (isa_rd_dat),
        .isa_rd_dat_vld_i  (isa_rd_dat_vld),
        .isa_rd_dat_rdy_o  (isa_rd_dat_rdy),
        .isa_rd_addr_min_o (isa_rd_addr_min),
        .mdu_rst_o         (mdu_rst),
        .knn_cfg_vld_o     (knn_cfg_vld),
        .knn_cfg_rdy_i     (knn_cfg_rdy),
        .knn_cfg_o         (knn_cfg),
        .sya_cfg_vld_o     (sya_cfg_vld),
        .sya_cfg_rdy_i     (sya_cfg_rdy),
        .sya_cfg_o         (sya_cfg)
    );

    isa_ram_model ram0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr_i     (isa_rd_addr),
        .addr_vld_i (isa_rd_addr_vld),
        .addr_rdy_o (isa_rd_addr_rdy),
        .dat_o      (isa_rd_dat),
        .dat_vld_o  (isa_rd_dat_vld),
        .dat_rdy_i  (isa_rd_dat_rdy)
    );

    task automatic report_mismatch(input string name, input logic [255:0] got,
                                   input logic [255:0] want);
        assert_errs++;
        $display("FAIL %s got %0h expected %0h", name, got, want);
    endtask

    // Control word, then KNN word and SYA pair per layer
    task automatic load_program();
        logic [63:0]  r64;
        logic [159:0] r160;
        logic [247:0] pay;
        ram0.mem[0] = {248'({20'(N_LY), 8'h01}), OP_CCU};   // Layer count over mode
        for (int i = 0; i < N_LY; i++) begin
            r64  = {$urandom, $urandom};
            r160 = {$urandom, $urandom, $urandom, $urandom, $urandom};
            exp_knn[i] = r64[$bits(knn_cfg_t)-1:0];
            exp_sya[i] = r160[$bits(sya_cfg_t)-1:0];
            pay = 248'({exp_knn[i].map_wr_addr, exp_knn[i].crd_rd_addr,
                        exp_knn[i].k, exp_knn[i].nip});
            ram0.mem[1 + 3*i] = {pay, OP_KNN};
            pay = 248'({exp_sya[i].lop_ord, exp_sya[i].num_til_flt, exp_sya[i].num_til_ifm,
                        exp_sya[i].num_grp_per_tile, exp_sya[i].zp, exp_sya[i].shift,
                        exp_sya[i].scale, exp_sya[i].chn, exp_sya[i].ofm_phase_shift,
                        exp_sya[i].mode});
            ram0.mem[2 + 3*i] = {pay, OP_SYA};
            pay = 248'({exp_sya[i].ofm_wr_base, exp_sya[i].wgt_rd_base,
                        exp_sya[i].act_rd_base});
            ram0.mem[3 + 3*i] = {pay, OP_SYA};
        end
    endtask

    // ==================================================
    // Module models and bookkeeping
    // ==================================================
    // SYA trails KNN so every KNN config is taken before the finish
    always @(negedge clk) begin
        knn_cfg_rdy <= started && knn_cnt < N_LY && ($urandom % 4 != 0);
        sya_cfg_rdy <= started && sya_cnt < knn_cnt && ($urandom % 4 != 0);
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (knn_cfg_vld && knn_cfg_rdy)
                knn_cnt <= knn_cnt + 1;
            if (sya_cfg_vld && sya_cfg_rdy)
                sya_cnt <= sya_cnt + 1;
            if (net_fnh)
                fnh_cnt <= fnh_cnt + 1;
            if (addr_hs)
                first_pend <= 1'b0;
            // A new selection restarts the address order
            if ((knn_cfg_vld && knn_cfg_rdy) || (sya_cfg_vld && sya_cfg_rdy)
                || (dat_hs && !ccu_seen)) begin
                have_prev <= 1'b0;
            end else if (addr_hs) begin
                have_prev <= 1'b1;
                prev_addr <= isa_rd_addr;
            end
            if (dat_hs)
                ccu_seen <= 1'b1;
            if (mdu_rst)
                min_peak <= '0;
            else if (isa_rd_addr_min > min_peak)
                min_peak <= isa_rd_addr_min;
        end
    end

    // ==================================================
    // Assertions
    // ==================================================
    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !knn_cfg_vld && !sya_cfg_vld && !isa_rd_addr_vld && !isa_rd_dat_rdy
                     && !net_fnh && mdu_rst)
        else report_mismatch({"{knn_cfg_vld_o,sya_cfg_vld_o,isa_rd_addr_vld_o,",
                              "isa_rd_dat_rdy_o,net_fnh_o,mdu_rst_o}"},
            {$sampled(knn_cfg_vld), $sampled(sya_cfg_vld), $sampled(isa_rd_addr_vld),
             $sampled(isa_rd_dat_rdy), $sampled(net_fnh), $sampled(mdu_rst)}, 6'b000001);

    a_first_addr: assert property (@(posedge clk) disable iff (!rst_n)
        addr_hs && first_pend |-> isa_rd_addr == '0)
        else report_mismatch("isa_rd_addr_o", $sampled(isa_rd_addr), 0);

    a_addr_order: assert property (@(posedge clk) disable iff (!rst_n)
        addr_hs && have_prev |-> isa_rd_addr >= prev_addr)
        else report_mismatch("isa_rd_addr_o", $sampled(isa_rd_addr), $sampled(prev_addr));

    a_knn_cfg: assert property (@(posedge clk) disable iff (!rst_n)
        knn_cfg_vld |-> knn_cfg == exp_knn[knn_cnt])
        else report_mismatch("knn_cfg_o", $sampled(knn_cfg), exp_knn[$sampled(knn_cnt)]);

    a_knn_hold: assert property (@(posedge clk) disable iff (!rst_n)
        knn_cfg_vld && !knn_cfg_rdy |=> knn_cfg_vld)
        else report_mismatch("knn_cfg_vld_o", $sampled(knn_cfg_vld), 1);

    a_sya_cfg: assert property (@(posedge clk) disable iff (!rst_n)
        sya_cfg_vld |-> sya_cfg == exp_sya[sya_cnt])
        else report_mismatch("sya_cfg_o", $sampled(sya_cfg), exp_sya[$sampled(sya_cnt)]);

    a_sya_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sya_cfg_vld && !sya_cfg_rdy |=> sya_cfg_vld)
        else report_mismatch("sya_cfg_vld_o", $sampled(sya_cfg_vld), 1);

    // No earlier minimum pointer lies above an address issued later
    a_min_below: assert property (@(posedge clk) disable iff (!rst_n)
        addr_hs |-> isa_rd_addr >= min_peak)
        else report_mismatch("isa_rd_addr_min_o", $sampled(min_peak),
                             $sampled(isa_rd_addr));

    a_min_rising: assert property (@(posedge clk) disable iff (!rst_n)
        !mdu_rst && !$past(mdu_rst) |-> isa_rd_addr_min >= $past(isa_rd_addr_min))
        else report_mismatch("isa_rd_addr_min_o", $sampled(isa_rd_addr_min),
                             $past(isa_rd_addr_min));

    a_fnh_layers: assert property (@(posedge clk) disable iff (!rst_n)
        net_fnh |-> sya_cnt == N_LY)
        else report_mismatch("net_fnh_o layer count", $sampled(sya_cnt), N_LY);

    a_fnh_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        net_fnh |=> !net_fnh && mdu_rst)
        else report_mismatch("{net_fnh_o,mdu_rst_o}",
                             {$sampled(net_fnh), $sampled(mdu_rst)}, 2'b01);

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        void'($urandom(27));
        @(negedge clk);
        load_program();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);      // Idle outputs get sampled
        start   = 1'b1;
        started = 1'b1;
        @(negedge clk);
        start = 1'b0;

        for (cyc = 0; cyc < TIMEOUT && fnh_cnt == 0; cyc++)
            @(negedge clk);
        if (fnh_cnt == 0) begin
            other_errs++;
            $display("Timeout: network finish never came after %0d cycles", TIMEOUT);
        end
        repeat (4) @(negedge clk);

        assert (knn_cnt == N_LY) else begin
            other_errs++;
            $display("Only %0d of %0d KNN configurations were taken", knn_cnt, N_LY);
        end
        assert (sya_cnt == N_LY) else begin
            other_errs++;
            $display("Only %0d of %0d SYA configurations were taken", sya_cnt, N_LY);
        end
        assert (fnh_cnt == 1) else begin
            other_errs++;
            $display("Network finish pulsed %0d times instead of once", fnh_cnt);
        end

        $display("Errors: %0d assertion, %0d other", assert_errs, other_errs);
        if (assert_errs == 0 && other_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* verif/isa_ram_model.sv */
/*
 * Behavioral instruction RAM for the CCU testbench. Address ready is
 * random, words come back in address order after a random delay.
 * The testbench writes its program straight into mem.
 */
`timescale 1ns/1ns
`include "ccu_defs.svh"

module isa_ram_model (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CCU_ADDR_WIDTH-1:0]  addr_i,
    input  logic                        addr_vld_i,
    output logic                        addr_rdy_o,
    output logic [`CCU_SRAM_WIDTH-1:0]  dat_o,
    output logic                        dat_vld_o,
    input  logic                        dat_rdy_i
);
    localparam int DEPTH = 64;

    logic [`CCU_SRAM_WIDTH-1:0] mem [0:DEPTH-1];
    logic [`CCU_SRAM_WIDTH-1:0] rd_q [$];           // Words on their way back
    int                         gap      = 0;       // Cycles before next word
    logic                       addr_rdy = 1'b0;
    logic                       dat_vld  = 1'b0;
    logic [`CCU_SRAM_WIDTH-1:0] dat      = '0;

    // Unused words carry opcode 8'hFF
    initial begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = {{31{2'b10, 6'(i)}}, 8'hFF};
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q.delete();
            gap = 0;
        end else begin
            if (dat_vld && dat_rdy_i) begin
                void'(rd_q.pop_front());
                gap = $urandom % 4;
            end else if (gap != 0)
                gap = gap - 1;
            if (addr_vld_i && addr_rdy) begin
                if (rd_q.size() == 0 && gap == 0)
                    gap = $urandom % 4;             // Delay of a fresh read
                rd_q.push_back(mem[addr_i % DEPTH]);
            end
        end
    end

    always @(negedge clk) begin
        addr_rdy <= rst_n && ($urandom % 4 != 0);
        dat_vld  <= rst_n && rd_q.size() != 0 && gap == 0;
        dat      <= (rd_q.size() != 0) ? rd_q[0] : '0;
    end

    assign addr_rdy_o = addr_rdy;
    assign dat_vld_o  = dat_vld;
    assign dat_o      = dat;

endmodule

/* rtl/ccu_top.sv */
/*
 * Configuration control unit top. Connects the control FSM, one
 * requester slot per opcode, the fetch stage and the decoder.
 * Start it with a pulse on start_i; net_fnh_o marks the end.
 */
`timescale 1ns/1ns
`include "ccu_defs.svh"

module ccu_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    output logic                          net_fnh_o,
    output logic [`CCU_ADDR_WIDTH-1:0]    isa_rd_addr_o,
    output logic                          isa_rd_addr_vld_o,
    input  logic                          isa_rd_addr_rdy_i,
    input  logic [`CCU_SRAM_WIDTH-1:0]    isa_rd_dat_i,
    input  logic                          isa_rd_dat_vld_i,
    output logic                          isa_rd_dat_rdy_o,
    output logic [`CCU_ADDR_WIDTH-1:0]    isa_rd_addr_min_o,
    output logic                          mdu_rst_o,
    output logic                          knn_cfg_vld_o,
    input  logic                          knn_cfg_rdy_i,
    output ccu_pkg::knn_cfg_t             knn_cfg_o,
    output logic                          sya_cfg_vld_o,
    input  logic                          sya_cfg_rdy_i,
    output ccu_pkg::sya_cfg_t             sya_cfg_o
);
    import ccu_pkg::*;

    ccu_state_e                     state;
    req_idx_t                       sel_idx;
    req_idx_t                       last_idx;
    slot_stat_t [`CCU_NUM_REQ-1:0]  slot_stat;
    logic [`CCU_NUM_REQ-1:0]        cfg_rdy;
    logic [`CCU_NUM_REQ-1:0]        req;
    logic                           self_rdy;
    logic                           addr_hs;
    logic                           last_hs;
    isa_word_t                      word;
    logic                           word_vld;
    logic [1:0]                     word_num;
    logic [`CCU_LAYER_WIDTH-1:0]    cfg_num_ly;

    // Slot order follows the opcode values
    assign cfg_rdy       = {sya_cfg_rdy_i, knn_cfg_rdy_i, self_rdy};
    assign mdu_rst_o     = state == CCU_IDLE;
    assign knn_cfg_vld_o = slot_stat[1].cfg_vld;
    assign sya_cfg_vld_o = slot_stat[2].cfg_vld;

    // ==================================================
    // Control
    // ==================================================
    ccu_ctrl_fsm u_ctrl_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .req_i        (req),
        .sel_vld_i    (slot_stat[sel_idx].cfg_vld),
        .sel_rdy_i    (slot_stat[sel_idx].rdy),
        .self_vld_i   (slot_stat[0].cfg_vld),
        .sya_hs_i     (sya_cfg_vld_o && sya_cfg_rdy_i),
        .cfg_num_ly_i (cfg_num_ly),
        .state_o      (state),
        .sel_idx_o    (sel_idx),
        .self_rdy_o   (self_rdy),
        .net_fnh_o    (net_fnh_o)
    );

    genvar g;
    generate
        for (g = 0; g < `CCU_NUM_REQ; g++) begin : g_slot
            ccu_req_slot u_slot (
                .clk        (clk),
                .rst_n      (rst_n),
                .clear_i    (mdu_rst_o),
                .addr_inc_i (addr_hs && sel_idx == g),
                .cfg_set_i  (last_hs && last_idx == g),
                .cfg_rdy_i  (cfg_rdy[g]),
                .stat_o     (slot_stat[g])
            );
            assign req[g] = slot_stat[g].rdy;
        end
    endgenerate

    // ==================================================
    // Fetch and decode
    // ==================================================
    isa_fetch u_fetch (
        .clk               (clk),
        .rst_n             (rst_n),
        .state_i           (state),
        .sel_idx_i         (sel_idx),
        .slot_i            (slot_stat),
        .isa_rd_addr_o     (isa_rd_addr_o),
        .isa_rd_addr_vld_o (isa_rd_addr_vld_o),
        .isa_rd_addr_rdy_i (isa_rd_addr_rdy_i),
        .isa_rd_dat_i      (isa_rd_dat_i),
        .isa_rd_dat_vld_i  (isa_rd_dat_vld_i),
        .isa_rd_dat_rdy_o  (isa_rd_dat_rdy_o),
        .addr_hs_o         (addr_hs),
        .last_hs_o         (last_hs),
        .last_idx_o        (last_idx),
        .word_o            (word),
        .word_vld_o        (word_vld),
        .word_num_o        (word_num),
        .addr_min_o        (isa_rd_addr_min_o)
    );

    isa_decoder u_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .word_i       (word),
        .word_vld_i   (word_vld),
        .word_num_i   (word_num),
        .cfg_num_ly_o (cfg_num_ly),
        .mode_o       (),            // No mode consumer at this level
        .knn_cfg_o    (knn_cfg_o),
        .sya_cfg_o    (sya_cfg_o)
    );

endmodule

/* rtl/isa_decoder.sv */
/*
 * Loads configuration registers from accepted instruction words.
 * Fields are taken by opcode and by word number within the opcode.
 */
`timescale 1ns/1ns
`include "ccu_defs.svh"

module isa_decoder (
    input  logic                           clk,
    input  logic                           rst_n,
    input  ccu_pkg::isa_word_t             word_i,
    input  logic                           word_vld_i,
    input  logic [1:0]                     word_num_i,
    output logic [`CCU_LAYER_WIDTH-1:0]    cfg_num_ly_o,
    output logic [`CCU_OPCODE_WIDTH-1:0]   mode_o,
    output ccu_pkg::knn_cfg_t              knn_cfg_o,
    output ccu_pkg::sya_cfg_t              sya_cfg_o
);
    import ccu_pkg::*;

    localparam int CCU_BITS    = `CCU_LAYER_WIDTH + `CCU_OPCODE_WIDTH;
    localparam int KNN_BITS    = $bits(knn_cfg_t);
    localparam int SYA_W1_BITS = 3 * `CCU_ADDR_WIDTH;          // Base addresses
    localparam int SYA_W0_BITS = $bits(sya_cfg_t) - SYA_W1_BITS;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_num_ly_o <= '0;
            mode_o       <= '0;
            knn_cfg_o    <= '0;
            sya_cfg_o    <= '0;
        end else if (word_vld_i) begin
            case (word_i.opcode)
                // Mode byte first, layer count above it
                OP_CCU: {cfg_num_ly_o, mode_o} <= word_i.payload[0 +: CCU_BITS];
                OP_KNN: begin
                    {knn_cfg_o.map_wr_addr,
                     knn_cfg_o.crd_rd_addr,
                     knn_cfg_o.k,
                     knn_cfg_o.nip} <= word_i.payload[0 +: KNN_BITS];
                end
                OP_SYA: begin
                    if (word_num_i == 2'd0) begin
                        {sya_cfg_o.lop_ord,
                         sya_cfg_o.num_til_flt,
                         sya_cfg_o.num_til_ifm,
                         sya_cfg_o.num_grp_per_tile,
                         sya_cfg_o.zp,
                         sya_cfg_o.shift,
                         sya_cfg_o.scale,
                         sya_cfg_o.chn,
                         sya_cfg_o.ofm_phase_shift,
                         sya_cfg_o.mode} <= word_i.payload[0 +: SYA_W0_BITS];
                    end else begin
                        {sya_cfg_o.ofm_wr_base,
                         sya_cfg_o.wgt_rd_base,
                         sya_cfg_o.act_rd_base} <= word_i.payload[0 +: SYA_W1_BITS];
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* rtl/isa_fetch.sv */
/*
 * Instruction fetch stage. Issues read addresses from the selected
 * slot's pointer, accepts returning words, counts words per opcode
 * and reports the last one. Also gives the lowest live pointer.
 */
`timescale 1ns/1ns
`include "ccu_defs.svh"

module isa_fetch (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  ccu_pkg::ccu_state_e                    state_i,
    input  ccu_pkg::req_idx_t                      sel_idx_i,
    input  ccu_pkg::slot_stat_t [`CCU_NUM_REQ-1:0] slot_i,
    output logic [`CCU_ADDR_WIDTH-1:0]             isa_rd_addr_o,
    output logic                                   isa_rd_addr_vld_o,
    input  logic                                   isa_rd_addr_rdy_i,
    input  logic [`CCU_SRAM_WIDTH-1:0]             isa_rd_dat_i,
    input  logic                                   isa_rd_dat_vld_i,
    output logic                                   isa_rd_dat_rdy_o,
    output logic                                   addr_hs_o,
    output logic                                   last_hs_o,
    output ccu_pkg::req_idx_t                      last_idx_o,
    output ccu_pkg::isa_word_t                     word_o,
    output logic                                   word_vld_o,
    output logic [1:0]                             word_num_o,
    output logic [`CCU_ADDR_WIDTH-1:0]             addr_min_o
);
    import ccu_pkg::*;

    req_idx_t                     idx_s1;     // Slot of the word in flight
    ccu_state_e                   state_s1;
    logic [`CCU_OPCODE_WIDTH-1:0] idx_op;
    logic [1:0]                   word_cnt;
    logic                         pend;       // Address out, data not back
    logic                         done;       // Last word seen in this CFG
    logic                         dat_hs;
    logic                         is_last;

    // Words per opcode
    function automatic logic [1:0] op_num_word(input ccu_opcode_e op);
        case (op)
            OP_SYA:  op_num_word = 2'd2;
            default: op_num_word = 2'd1;
        endcase
    endfunction

    // ==================================================
    // Address side
    // ==================================================
    assign isa_rd_addr_o     = slot_i[sel_idx_i].rd_ptr;
    // One word in flight so no word past the last is consumed
    assign isa_rd_addr_vld_o = (state_i == CCU_CFG) && !done && !last_hs_o
                               && (!pend || dat_hs);
    assign addr_hs_o         = isa_rd_addr_vld_o && isa_rd_addr_rdy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_s1   <= '0;
            state_s1 <= CCU_IDLE;
        end else if (addr_hs_o) begin
            idx_s1   <= sel_idx_i;
            state_s1 <= state_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pend <= 1'b0;
        else if (addr_hs_o)
            pend <= 1'b1;
        else if (dat_hs)
            pend <= 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            done <= 1'b0;
        else if (state_i != CCU_CFG)
            done <= 1'b0;
        else if (last_hs_o)
            done <= 1'b1;
    end

    // ==================================================
    // Data side
    // ==================================================
    assign isa_rd_dat_rdy_o = state_s1 == CCU_CFG;
    assign dat_hs           = isa_rd_dat_vld_i && isa_rd_dat_rdy_o;
    assign word_o           = isa_word_t'(isa_rd_dat_i);
    assign idx_op           = `CCU_OPCODE_WIDTH'(idx_s1);
    assign word_vld_o       = dat_hs && (word_o.opcode == idx_op);  // Others dropped
    assign is_last          = word_cnt == op_num_word(word_o.opcode) - 2'd1;
    assign last_hs_o        = word_vld_o && is_last;
    assign last_idx_o       = idx_s1;
    assign word_num_o       = word_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            word_cnt <= '0;
        else if (last_hs_o)
            word_cnt <= '0;
        else if (word_vld_o)
            word_cnt <= word_cnt + 2'd1;
    end

    // Lowest pointer still needed by any slot
    always_comb begin
        addr_min_o = slot_i[0].rd_ptr;
        for (int i = 1; i < `CCU_NUM_REQ; i++) begin
            if (slot_i[i].rd_ptr < addr_min_o)
                addr_min_o = slot_i[i].rd_ptr;
        end
    end

endmodule

/* rtl/ccu_req_slot.sv */
/*
 * One requester slot: instruction read pointer plus the config
 * valid flag offered to the module. Instantiated once per opcode.
 */
`timescale 1ns/1ns
`include "ccu_defs.svh"

module ccu_req_slot (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear_i,     // Network idle
    input  logic                 addr_inc_i,  // Address handshake for this slot
    input  logic                 cfg_set_i,   // Last word of this slot accepted
    input  logic                 cfg_rdy_i,
    output ccu_pkg::slot_stat_t  stat_o
);
    logic [`CCU_ADDR_WIDTH-1:0] rd_ptr;
    logic                       cfg_vld;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_ptr <= '0;
        else if (clear_i)
            rd_ptr <= '0;
        else if (addr_inc_i)
            rd_ptr <= rd_ptr + 1'b1;
    end

    // Held until the module is ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cfg_vld <= 1'b0;
        else if (cfg_vld && cfg_rdy_i)
            cfg_vld <= 1'b0;
        else if (cfg_set_i)
            cfg_vld <= 1'b1;
    end

    assign stat_o.rdy     = cfg_rdy_i;
    assign stat_o.cfg_vld = cfg_vld;
    assign stat_o.rd_ptr  = rd_ptr;

endmodule

/* rtl/ccu_ctrl_fsm.sv */
/*
 * Control FSM of the configuration unit. Arbitrates pending config
 * requests by fixed priority, counts SYA layers, and owns the
 * ready flag of the unit's own control word.
 */
`timescale 1ns/1ns
`include "ccu_defs.svh"

module ccu_ctrl_fsm (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_i,
    input  logic [`CCU_NUM_REQ-1:0]      req_i,
    input  logic                         sel_vld_i,
    input  logic                         sel_rdy_i,
    input  logic                         self_vld_i,
    input  logic                         sya_hs_i,
    input  logic [`CCU_LAYER_WIDTH-1:0]  cfg_num_ly_i,
    output ccu_pkg::ccu_state_e          state_o,
    output ccu_pkg::req_idx_t            sel_idx_o,
    output logic                         self_rdy_o,
    output logic                         net_fnh_o
);
    import ccu_pkg::*;

    ccu_state_e                  state;
    ccu_state_e                  next_state;
    req_idx_t                    arb_idx;
    logic [`CCU_LAYER_WIDTH-1:0] num_ly;
    logic                        ly_done;

    // ==================================================
    // Fixed priority arbiter
    // ==================================================
    always_comb begin
        arb_idx = '0;
        for (int i = `CCU_NUM_REQ - 1; i >= 0; i--) begin
            if (req_i[i])
                arb_idx = req_idx_t'(i);   // Lowest index wins
        end
    end

    assign ly_done = (num_ly == cfg_num_ly_i) && (cfg_num_ly_i != '0);

    // ==================================================
    // State machine
    // ==================================================
    always_comb begin
        next_state = state;
        case (state)
            CCU_IDLE:     if (start_i) next_state = CCU_IDLE_CFG;
            CCU_IDLE_CFG: begin
                if (ly_done)
                    next_state = CCU_NETFNH;
                else if (|req_i)
                    next_state = CCU_CFG;
            end
            CCU_CFG: begin
                if (ly_done)
                    next_state = CCU_NETFNH;
                else if (sel_vld_i && sel_rdy_i)   // Selected module took its config
                    next_state = CCU_IDLE_CFG;
            end
            default:      next_state = CCU_IDLE;   // NETFNH
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CCU_IDLE;
            sel_idx_o <= '0;
        end else begin
            state <= next_state;
            if (state == CCU_IDLE_CFG && next_state == CCU_CFG)
                sel_idx_o <= arb_idx;
        end
    end

    // Layers advance on every SYA config handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            num_ly <= '0;
        else if (state == CCU_IDLE)
            num_ly <= '0;
        else if (sya_hs_i)
            num_ly <= num_ly + 1'b1;
    end

    // Own control word is fetched once per network
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            self_rdy_o <= 1'b1;
        else if (self_vld_i && self_rdy_o)
            self_rdy_o <= 1'b0;
        else if (state == CCU_IDLE)
            self_rdy_o <= 1'b1;
    end

    assign state_o   = state;
    assign net_fnh_o = state == CCU_NETFNH;

endmodule

/* rtl/ccu_pkg.sv */
/*
 * Shared types of the configuration control unit: FSM states,
 * opcodes, requester slot status and the decoded configurations.
 */
`include "ccu_defs.svh"

package ccu_pkg;

    typedef enum logic [1:0] {
        CCU_IDLE     = 2'd0,
        CCU_IDLE_CFG = 2'd1,
        CCU_CFG      = 2'd2,
        CCU_NETFNH   = 2'd3
    } ccu_state_e;

    // Opcode value doubles as the requester slot index
    typedef enum logic [`CCU_OPCODE_WIDTH-1:0] {
        OP_CCU = 8'd0,  // One word
        OP_KNN = 8'd1,  // One word
        OP_SYA = 8'd2   // Two words
    } ccu_opcode_e;

    typedef logic [1:0] req_idx_t;

    typedef struct packed {
        logic                       rdy;        // Module asks for a config
        logic                       cfg_vld;
        logic [`CCU_ADDR_WIDTH-1:0] rd_ptr;
    } slot_stat_t;

    // First field sits at payload bit 0
    typedef struct packed {
        logic [`CCU_IDX_WIDTH-1:0]  nip;
        logic [`CCU_MAP_WIDTH:0]    k;
        logic [`CCU_IDX_WIDTH-1:0]  crd_rd_addr;
        logic [`CCU_IDX_WIDTH-1:0]  map_wr_addr;
    } knn_cfg_t;

    typedef struct packed {
        logic [1:0]                 mode;       // Word 0 from here
        logic                       ofm_phase_shift;
        logic [`CCU_CHN_WIDTH-1:0]  chn;
        logic [`CCU_QNTSL_WIDTH-1:0] scale;
        logic [`CCU_ACT_WIDTH-1:0]  shift;
        logic [`CCU_ACT_WIDTH-1:0]  zp;
        logic [`CCU_IDX_WIDTH-1:0]  num_grp_per_tile;
        logic [`CCU_IDX_WIDTH-1:0]  num_til_ifm;
        logic [`CCU_IDX_WIDTH-1:0]  num_til_flt;
        logic                       lop_ord;
        logic [`CCU_ADDR_WIDTH-1:0] act_rd_base;    // Word 1 from here
        logic [`CCU_ADDR_WIDTH-1:0] wgt_rd_base;
        logic [`CCU_ADDR_WIDTH-1:0] ofm_wr_base;
    } sya_cfg_t;

    typedef struct packed {
        logic [`CCU_SRAM_WIDTH-`CCU_OPCODE_WIDTH-1:0] payload;
        ccu_opcode_e                                  opcode;
    } isa_word_t;

endpackage

/* include/ccu_defs.svh */
/*
 * Width and count macros for the configuration control unit.
 * Include wherever a port or register width is needed.
 */
`ifndef CCU_DEFS_SVH
`define CCU_DEFS_SVH

// Instruction RAM
`define CCU_ADDR_WIDTH      16      // RAM address and read pointer
`define CCU_SRAM_WIDTH      256     // One instruction word
`define CCU_OPCODE_WIDTH    8       // Low bits of every word

// Requesters
`define CCU_NUM_REQ         3       // CCU self, KNN, SYA

// Configuration fields
`define CCU_LAYER_WIDTH     20
`define CCU_IDX_WIDTH       16      // Point and tile counts
`define CCU_CHN_WIDTH       12
`define CCU_QNTSL_WIDTH     20      // Quantization scale
`define CCU_ACT_WIDTH       8
`define CCU_MAP_WIDTH       5       // Neighbor map index

`endif
